// ==== Makefile ====
TOP       ?= icache_tb
FILELIST  ?= icache_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/icache_chk.sv ====
module icache_chk (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  icache_pkg::op_e         req_op,
    input  logic                    req_ready,
    input  logic                    mem_req,
    input  logic                    mem_addr_ok,
    input  logic                    resp_valid,
    input  logic                    resp_ready,
    input  icache_pkg::ctrl_state_e state
);

    int fail_count = 0;

    // pending request keeps valid and opcode until taken
    req_held: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_op))
        else begin
            $error("request dropped or changed before it was accepted");
            fail_count++;
        end

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req)
        else begin
            $error("memory request dropped before address accept");
            fail_count++;
        end

    resp_held: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid)
        else begin
            $error("response dropped before it was taken");
            fail_count++;
        end

    // response is visible exactly while the controller waits in respond
    resp_in_respond: assert property (@(posedge clk) disable iff (rst)
        resp_valid == (state == icache_pkg::s_respond))
        else begin
            $error("resp_valid out of step with the respond state");
            fail_count++;
        end

endmodule

bind icache_ctrl icache_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_ready   (req_ready),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .state       (state)
);

// ==== dv/icache_tb.sv ====
module icache_tb;

    localparam int num_entries = 16;
    localparam int cycle_limit = num_entries * 40;

    typedef struct packed {
        icache_pkg::op_e op;
        logic [31:0]     addr;
        logic            miss;
    } entry_t;

    logic                              clk;
    logic                              rst;
    logic                              req_valid;
    logic [31:0]                       req_addr;
    icache_pkg::op_e                   req_op;
    logic                              req_ready;
    logic                              resp_valid;
    logic [31:0]                       resp_pc;
    logic [63:0]                       resp_data;
    logic                              resp_flag;
    logic                              resp_ready;
    logic                              mem_req;
    logic [31:0]                       mem_addr;
    logic                              mem_addr_ok;
    logic                              mem_data_ok;
    logic [icache_pkg::line_width-1:0] mem_rdata;

    logic [15:0] lfsr = 16'd12191;
    int          mem_req_count = 0;
    logic [31:0] last_mem_addr;
    int          cycle_count = 0;

    // reference tag, valid and lru state
    logic [icache_pkg::tag_width-1:0] model_tag [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_sets-1:0]  model_valid [icache_pkg::num_ways] = '{default: '0};
    logic [icache_pkg::num_sets-1:0]  model_lru = '0;

    // set 0 sees three tags, set 5 a short line walk
    entry_t stim_table [num_entries] = '{
        '{icache_pkg::op_fetch,       32'h0000_1000, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_1004, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_1008, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_100C, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_2000, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_1004, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_3000, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_2008, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_3004, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_1000, 1'b1},
        '{icache_pkg::op_index_inval, 32'h0000_1000, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_3000, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_1008, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_0050, 1'b1},
        '{icache_pkg::op_fetch,       32'h0000_005C, 1'b0},
        '{icache_pkg::op_fetch,       32'h0000_3008, 1'b0}
    };

    icache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_bit());
        end
        return val;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return byte_addr ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [icache_pkg::line_width-1:0] mem_line(input logic [31:0] line_addr);
        logic [icache_pkg::line_width-1:0] line;
        for (int i = 0; i < (1 << icache_pkg::offset_width); i++) begin
            line[32*i +: 32] = mem_word(line_addr + 32'(4 * i));
        end
        return line;
    endfunction

    // predicts a miss, updates the model on every access
    function automatic logic model_access(input icache_pkg::op_e op, input logic [31:0] addr);
        logic [icache_pkg::index_width-1:0] idx;
        logic [icache_pkg::tag_width-1:0]   tag;
        logic                               way;
        logic                               found;
        idx   = addr[7:4];
        tag   = addr[31:8];
        way   = model_lru[idx];
        found = 1'b0;
        if (op == icache_pkg::op_index_inval) begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                model_valid[w][idx] = 1'b0;
            end
        end else begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                    found = 1'b1;
                    way   = w[0];
                end
            end
            model_tag[way][idx]   = tag;
            model_valid[way][idx] = 1'b1;
            model_lru[idx]        = ~way;
        end
        return (op == icache_pkg::op_fetch) && !found;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_resp(input logic [31:0] got_pc, input logic [63:0] got_data,
                              input logic got_flag, input logic [31:0] addr);
        logic [31:0] base;
        logic [63:0] exp_data;
        logic        exp_flag;
        base = {addr[31:2], 2'b00};
        // odd word leaves the upper slot empty
        if (addr[2]) begin
            exp_data = {32'h0, mem_word(base)};
            exp_flag = 1'b0;
        end else begin
            exp_data = {mem_word(base + 32'd4), mem_word(base)};
            exp_flag = 1'b1;
        end
        if (got_pc !== addr) begin
            abort_run($sformatf("Mismatch resp_pc: got %h expected %h", got_pc, addr));
        end
        if (got_data !== exp_data) begin
            abort_run($sformatf("Mismatch resp_data: got %h expected %h", got_data, exp_data));
        end
        if (got_flag !== exp_flag) begin
            abort_run($sformatf("Mismatch resp_flag: got %h expected %h", got_flag, exp_flag));
        end
    endtask

    task automatic check_miss(input icache_pkg::op_e op, input int got_reqs,
                              input logic [31:0] got_addr, input logic exp_miss,
                              input logic [31:0] addr);
        int          exp_reqs;
        logic [31:0] exp_addr;
        exp_reqs = exp_miss ? 1 : 0;
        exp_addr = {addr[31:4], 4'h0};
        if (got_reqs != exp_reqs) begin
            abort_run($sformatf("Mismatch mem_req count (%s %h): got %h expected %h",
                                op.name(), addr, got_reqs, exp_reqs));
        end
        if (exp_miss && got_addr !== exp_addr) begin
            abort_run($sformatf("Mismatch mem_addr: got %h expected %h", got_addr, exp_addr));
        end
    endtask

    task automatic check_ctrl_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Mismatch hit latency: got %h expected %h", got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model and cycle limit
    //////////////////////////////////////////////////////////////////////

    initial begin
        int addr_delay;
        int data_delay;
        mem_addr_ok <= 1'b0;
        mem_data_ok <= 1'b0;
        mem_rdata   <= '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                mem_req_count++;
                last_mem_addr = mem_addr;
                addr_delay    = rand_bits(2);
                data_delay    = rand_bits(2);
                repeat (addr_delay + 1) @(posedge clk);
                mem_addr_ok <= 1'b1;
                @(posedge clk);
                mem_addr_ok <= 1'b0;
                repeat (data_delay + 1) @(posedge clk);
                mem_data_ok <= 1'b1;
                mem_rdata   <= mem_line(last_mem_addr);
                @(posedge clk);
                mem_data_ok <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout, the cache stopped answering within the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // one resp_ready pulse takes the held response
    task automatic release_resp();
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        resp_ready <= 1'b0;
        @(negedge clk);
        check_ctrl_bit("resp_valid", resp_valid, 1'b0);
        check_ctrl_bit("req_ready", req_ready, 1'b1);
    endtask

    task automatic run_entry(input entry_t e);
        int   count_before;
        int   lat;
        int   stall;
        logic pending;
        if (model_access(e.op, e.addr) !== e.miss) begin
            abort_run("stimulus table entry disagrees with the reference cache model");
        end
        pending      = resp_valid;
        count_before = mem_req_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req_addr  <= e.addr;
        req_op    <= e.op;
        // new request waits while the previous response drains
        if (pending) begin
            release_resp();
        end else begin
            @(negedge clk);
        end
        while (!req_ready) begin
            @(negedge clk);
        end
        // transfer edge
        @(posedge clk);
        req_valid <= 1'b0;
        if (e.op == icache_pkg::op_index_inval) begin
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            check_miss(e.op, mem_req_count - count_before, last_mem_addr, e.miss, e.addr);
        end else begin
            // counted from the start of the transfer cycle
            lat = 1;
            do begin
                @(posedge clk);
                lat++;
                @(negedge clk);
            end while (!resp_valid);
            if (!e.miss) begin
                check_latency(lat, 2);
            end
            check_miss(e.op, mem_req_count - count_before, last_mem_addr, e.miss, e.addr);
            check_resp(resp_pc, resp_data, resp_flag, e.addr);
            // back-pressure, response must hold
            stall = rand_bits(2);
            repeat (stall) begin
                @(posedge clk);
                @(negedge clk);
                check_resp(resp_pc, resp_data, resp_flag, e.addr);
                check_ctrl_bit("resp_valid", resp_valid, 1'b1);
                check_ctrl_bit("req_ready", req_ready, 1'b0);
            end
        end
    endtask

    initial begin
        rst        <= 1'b1;
        req_valid  <= 1'b0;
        req_addr   <= '0;
        req_op     <= icache_pkg::op_fetch;
        resp_ready <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_ctrl_bit("req_ready", req_ready, 1'b1);
        check_ctrl_bit("resp_valid", resp_valid, 1'b0);
        check_ctrl_bit("mem_req", mem_req, 1'b0);
        for (int i = 0; i < num_entries; i++) begin
            run_entry(stim_table[i]);
        end
        if (resp_valid) begin
            release_resp();
        end
        @(negedge clk);
        if (DUT.u_ctrl.u_chk.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("handshake assertions failed during the run");
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid,
    input  icache_pkg::op_e                 req_op,
    input  icache_pkg::op_e                 held_op,
    output logic                            req_ready,
    input  logic [icache_pkg::num_ways-1:0] hit,
    output logic                            mem_req,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    output logic                            load,
    output logic                            tag_wr,
    output logic                            data_wr,
    output logic                            inval,
    output logic                            touch,
    output logic                            touch_way,
    output logic                            capture,
    output logic                            use_refill,
    output logic                            sel_way,
    input  logic                            resp_valid,
    input  logic                            resp_ready,
    output icache_pkg::ctrl_state_e         state
);

    icache_pkg::ctrl_state_e next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::s_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and per-state strobes
    //////////////////////////////////////////////////////////////////////

    assign req_ready = (state == icache_pkg::s_idle);
    assign load      = req_valid && req_ready;
    assign mem_req   = (state == icache_pkg::s_miss_req);

    // way 1 hit picks way 1, otherwise way 0
    assign sel_way   = hit[1];
    assign touch_way = hit[1];

    always_comb begin
        next_state = state;
        tag_wr     = 1'b0;
        data_wr    = 1'b0;
        inval      = 1'b0;
        touch      = 1'b0;
        capture    = 1'b0;
        use_refill = 1'b0;
        case (state)
            icache_pkg::s_idle: begin
                if (load) begin
                    if (req_op == icache_pkg::op_index_inval) begin
                        next_state = icache_pkg::s_inval;
                    end else begin
                        next_state = icache_pkg::s_lookup;
                    end
                end
            end
            icache_pkg::s_lookup: begin
                if (|hit) begin
                    capture    = 1'b1;
                    touch      = 1'b1;
                    next_state = icache_pkg::s_respond;
                end else begin
                    next_state = icache_pkg::s_miss_req;
                end
            end
            icache_pkg::s_miss_req: begin
                if (mem_addr_ok) begin
                    next_state = icache_pkg::s_miss_wait;
                end
            end
            icache_pkg::s_miss_wait: begin
                // fill and answer on the same edge
                if (mem_data_ok) begin
                    tag_wr     = 1'b1;
                    data_wr    = 1'b1;
                    capture    = 1'b1;
                    use_refill = 1'b1;
                    next_state = icache_pkg::s_respond;
                end
            end
            icache_pkg::s_respond: begin
                if (resp_valid && resp_ready) begin
                    next_state = icache_pkg::s_idle;
                end
            end
            icache_pkg::s_inval: begin
                inval      = (held_op == icache_pkg::op_index_inval);
                next_state = icache_pkg::s_idle;
            end
            default: begin
                next_state = icache_pkg::s_idle;
            end
        endcase
    end

endmodule

// ==== hdl/icache_data_array.sv ====
module icache_data_array (
    input  logic                               clk,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    output logic [icache_pkg::line_width-1:0]  rd_line0,
    output logic [icache_pkg::line_width-1:0]  rd_line1,
    input  logic [icache_pkg::num_ways-1:0]    wr_en,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  logic [icache_pkg::line_width-1:0]  wr_line
);

    logic [icache_pkg::line_width-1:0] line_mem [icache_pkg::num_ways][icache_pkg::num_sets];

    // both ways read every cycle, the select stage picks one
    always_ff @(posedge clk) begin
        rd_line0 <= line_mem[0][rd_index];
        rd_line1 <= line_mem[1][rd_index];
    end

    // refill writes one whole line into the chosen way
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (wr_en[w]) begin
                line_mem[w][wr_index] <= wr_line;
            end
        end
    end

endmodule

// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    // 16 sets
    localparam int index_width = 4;

    // 4 words per line
    localparam int offset_width = 2;

    localparam int num_ways = 2;
    localparam int num_sets = 1 << index_width;

    // address bits above index, offset and byte select
    localparam int tag_width = 32 - 2 - index_width - offset_width;

    // whole refill line
    localparam int line_width = 32 * (1 << offset_width);

    //////////////////////////////////////////////////////////////////////
    // request opcodes and controller states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [0:0] {
        op_fetch       = 1'b0,
        // clears both ways of the set at the address index
        op_index_inval = 1'b1
    } op_e;

    typedef enum logic [2:0] {
        s_idle      = 3'd0,
        s_lookup    = 3'd1,
        s_miss_req  = 3'd2,
        s_miss_wait = 3'd3,
        s_respond   = 3'd4,
        s_inval     = 3'd5
    } ctrl_state_e;

endpackage

// ==== hdl/icache_req_stage.sv ====
module icache_req_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic [31:0]        req_addr,
    input  icache_pkg::op_e    req_op,
    output logic [31:0]        held_addr,
    output icache_pkg::op_e    held_op
);

    // address is payload, no reset needed
    always_ff @(posedge clk) begin
        if (load) begin
            held_addr <= req_addr;
        end
    end

    // opcode returns to a plain fetch after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            held_op <= icache_pkg::op_fetch;
        end else if (load) begin
            held_op <= req_op;
        end
    end

endmodule

// ==== hdl/icache_tag_array.sv ====
module icache_tag_array (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    input  logic [icache_pkg::tag_width-1:0] cmp_tag,
    output logic [icache_pkg::num_ways-1:0]  hit,
    input  logic                             wr_en,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  logic [icache_pkg::tag_width-1:0] wr_tag,
    input  logic                             inval,
    input  logic                             touch,
    input  logic                             touch_way,
    output logic                             victim
);

    logic [icache_pkg::tag_width-1:0] tag_mem [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_ways-1:0][icache_pkg::num_sets-1:0] valid_bits;
    logic [icache_pkg::num_sets-1:0] lru_bits;

    logic [icache_pkg::tag_width-1:0] rd_tag [icache_pkg::num_ways];
    logic [icache_pkg::num_ways-1:0]  rd_valid;

    //////////////////////////////////////////////////////////////////////
    // tag storage and registered read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            rd_tag[w]   <= tag_mem[w][rd_index];
            rd_valid[w] <= valid_bits[w][rd_index];
        end
        if (wr_en) begin
            tag_mem[victim][wr_index] <= wr_tag;
        end
    end

    // compare against the held request tag
    always_comb begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits and per-set lru
    //////////////////////////////////////////////////////////////////////

    // lru bit names the way to evict next
    assign victim = lru_bits[wr_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            lru_bits   <= '0;
        end else begin
            if (inval) begin
                for (int w = 0; w < icache_pkg::num_ways; w++) begin
                    valid_bits[w][wr_index] <= 1'b0;
                end
            end else if (wr_en) begin
                valid_bits[victim][wr_index] <= 1'b1;
                // freshly filled way becomes most recent
                lru_bits[wr_index]           <= ~victim;
            end
            if (touch) begin
                lru_bits[wr_index] <= ~touch_way;
            end
        end
    end

endmodule

// ==== hdl/icache_top.sv ====
module icache_top (
    input  logic                              clk,
    input  logic                              rst,
    // fetch side
    input  logic                              req_valid,
    input  logic [31:0]                       req_addr,
    input  icache_pkg::op_e                   req_op,
    output logic                              req_ready,
    output logic                              resp_valid,
    output logic [31:0]                       resp_pc,
    output logic [63:0]                       resp_data,
    output logic                              resp_flag,
    input  logic                              resp_ready,
    // memory side
    output logic                              mem_req,
    output logic [31:0]                       mem_addr,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [icache_pkg::line_width-1:0] mem_rdata
);

    logic [31:0]                         held_addr;
    icache_pkg::op_e                     held_op;
    logic                                load;
    logic [icache_pkg::index_width-1:0]  req_index;
    logic [icache_pkg::index_width-1:0]  held_index;
    logic [icache_pkg::index_width-1:0]  rd_index;
    logic [icache_pkg::tag_width-1:0]    held_tag;
    logic [icache_pkg::num_ways-1:0]     hit;
    logic                                victim;
    logic                                tag_wr;
    logic                                data_wr;
    logic [icache_pkg::num_ways-1:0]     data_wr_en;
    logic                                inval;
    logic                                touch;
    logic                                touch_way;
    logic                                capture;
    logic                                use_refill;
    logic                                sel_way;
    logic [icache_pkg::line_width-1:0]   line0;
    logic [icache_pkg::line_width-1:0]   line1;

    //////////////////////////////////////////////////////////////////////
    // address fields
    //////////////////////////////////////////////////////////////////////

    assign req_index  = req_addr[icache_pkg::offset_width+2 +: icache_pkg::index_width];
    assign held_index = held_addr[icache_pkg::offset_width+2 +: icache_pkg::index_width];
    assign held_tag   = held_addr[31 -: icache_pkg::tag_width];

    // arrays follow the incoming index only on the transfer
    assign rd_index = load ? req_index : held_index;

    assign mem_addr = {held_addr[31:icache_pkg::offset_width+2],
                       {(icache_pkg::offset_width+2){1'b0}}};

    // refill goes to the lru victim
    assign data_wr_en = {data_wr & victim, data_wr & ~victim};

    icache_req_stage u_req_stage (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .req_addr  (req_addr),
        .req_op    (req_op),
        .held_addr (held_addr),
        .held_op   (held_op)
    );

    icache_tag_array u_tag_array (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .cmp_tag   (held_tag),
        .hit       (hit),
        .wr_en     (tag_wr),
        .wr_index  (held_index),
        .wr_tag    (held_tag),
        .inval     (inval),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    icache_data_array u_data_array (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line0 (line0),
        .rd_line1 (line1),
        .wr_en    (data_wr_en),
        .wr_index (held_index),
        .wr_line  (mem_rdata)
    );

    icache_word_select u_word_select (
        .clk         (clk),
        .rst         (rst),
        .capture     (capture),
        .use_refill  (use_refill),
        .way         (sel_way),
        .line0       (line0),
        .line1       (line1),
        .refill_line (mem_rdata),
        .addr        (held_addr),
        .resp_ready  (resp_ready),
        .resp_valid  (resp_valid),
        .resp_pc     (resp_pc),
        .resp_data   (resp_data),
        .resp_flag   (resp_flag)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .held_op     (held_op),
        .req_ready   (req_ready),
        .hit         (hit),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .load        (load),
        .tag_wr      (tag_wr),
        .data_wr     (data_wr),
        .inval       (inval),
        .touch       (touch),
        .touch_way   (touch_way),
        .capture     (capture),
        .use_refill  (use_refill),
        .sel_way     (sel_way),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .state       ()
    );

endmodule

// ==== hdl/icache_word_select.sv ====
module icache_word_select (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              capture,
    input  logic                              use_refill,
    input  logic                              way,
    input  logic [icache_pkg::line_width-1:0] line0,
    input  logic [icache_pkg::line_width-1:0] line1,
    input  logic [icache_pkg::line_width-1:0] refill_line,
    input  logic [31:0]                       addr,
    input  logic                              resp_ready,
    output logic                              resp_valid,
    output logic [31:0]                       resp_pc,
    output logic [63:0]                       resp_data,
    output logic                              resp_flag
);

    logic [icache_pkg::line_width-1:0]   line;
    logic [icache_pkg::offset_width-1:0] word;
    logic [63:0]                         pair;

    // refill line bypasses the array on a miss
    assign line = use_refill ? refill_line : (way ? line1 : line0);
    assign word = addr[icache_pkg::offset_width+1:2];

    // aligned pair of words that holds the requested word
    assign pair = line[word[icache_pkg::offset_width-1:1]*64 +: 64];

    always_ff @(posedge clk) begin
        if (capture) begin
            resp_pc <= addr;
            if (word[0]) begin
                // odd word, upper slot unusable
                resp_data <= {32'h0, pair[63:32]};
                resp_flag <= 1'b0;
            end else begin
                resp_data <= pair;
                resp_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (capture) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

endmodule

// ==== icache_top.f ====
hdl/icache_pkg.sv
hdl/icache_req_stage.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_ctrl.sv
hdl/icache_word_select.sv
hdl/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv
